/* rtl/sd_cmd_rx.sv */
`timescale 1ns/1ns

module sd_cmd_rx #(
   parameter int RESET_WAIT_CLKS = 60
) (
   input  logic              sd_clk,
   input  logic              reset_n,
   input  logic              cmd_i,
   input  logic              cmd_oe_i,
   input  logic              crc_disable_i,
   output sd_pkg::cmd_word_t cmd_word_o,
   output logic              cmd_crc_good_o,
   output logic              cmd_act_o
);
   import sd_pkg::*;

   localparam int WAIT_W = (RESET_WAIT_CLKS > 1) ? $clog2(RESET_WAIT_CLKS) : 1;

   typedef enum logic [2:0] {
      ST_RESET,
      ST_RESET_WAIT,
      ST_IDLE,
      ST_READ,
      ST_CHECK
   } rx_state_t;

   rx_state_t             state;
   logic [WAIT_W-1:0]     wait_cnt;
   logic [5:0]            bit_cnt;
   logic                  cmd_last;
   logic                  start_bit;
   logic [CMD_BITS-2:0]   cmd_shift;
   crc7_t                 crc;

   // falling CMD edge in idle, but never our own response
   assign start_bit = (state == ST_IDLE) && !cmd_i && cmd_last && !cmd_oe_i;

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state          <= ST_RESET;
         wait_cnt       <= '0;
         bit_cnt        <= '0;
         cmd_last       <= 1'b0;
         cmd_crc_good_o <= 1'b0;
         cmd_act_o      <= 1'b0;
      end else begin
         cmd_last <= cmd_i;
         case (state)
            ST_RESET: begin
               wait_cnt <= '0;
               if (cmd_i) begin
                  state <= ST_RESET_WAIT;
               end
            end
            ST_RESET_WAIT: begin
               // host sends a run of idle clocks before the first command
               wait_cnt <= wait_cnt + 1'b1;
               if (wait_cnt == WAIT_W'(RESET_WAIT_CLKS - 1)) begin
                  state <= ST_IDLE;
               end
            end
            ST_IDLE: begin
               if (start_bit) begin
                  cmd_act_o <= 1'b0;
                  bit_cnt   <= '0;
                  state     <= ST_READ;
               end
            end
            ST_READ: begin
               bit_cnt <= bit_cnt + 1'b1;
               // last CRC bit shifted in, end bit comes next
               if (bit_cnt == 6'd45) begin
                  state <= ST_CHECK;
               end
            end
            ST_CHECK: begin
               cmd_crc_good_o <= crc_disable_i | (cmd_shift[CRC7_BITS-1:0] == crc);
               // transmission bit
               cmd_act_o      <= cmd_shift[CMD_BITS-3];
               state          <= ST_IDLE;
            end
            default: begin
               state <= ST_RESET;
            end
         endcase
      end
   end

   // frame shift register and running CRC
   always_ff @(posedge sd_clk) begin
      if (start_bit) begin
         cmd_shift <= '0;
         crc       <= '0;
      end else if (state == ST_READ) begin
         cmd_shift <= {cmd_shift[CMD_BITS-3:0], cmd_i};
         // start bit leaves a zero CRC, so only bits 1 to 39 need stepping
         if (bit_cnt < 6'd39) begin
            crc <= crc7_step(crc, cmd_i);
         end
      end else if (state == ST_CHECK) begin
         cmd_word_o <= {cmd_shift, cmd_i};
      end
   end

   a_bit_cnt_range : assert property (
      @(posedge sd_clk) disable iff (!reset_n)
      (state == ST_READ) |-> (bit_cnt <= 6'd46)
   );

endmodule

/* rtl/sd_host_sync.sv */
`timescale 1ns/1ns

module sd_host_sync #(
   parameter int SYNC_STAGES = 3
) (
   input  logic               sd_clk,
   input  logic               reset_n,
   input  logic               resp_act_i,
   input  sd_pkg::resp_type_t resp_type_i,
   input  logic               crc_disable_i,
   output logic               resp_start_o,
   output sd_pkg::resp_type_t resp_type_o,
   output logic               crc_disable_o
);
   import sd_pkg::*;

   localparam int TYPE_W = $bits(resp_type_t);
   localparam int SYNC_W = TYPE_W + 2;

   // request level, crc setting and response type share one chain
   logic [SYNC_STAGES-1:0][SYNC_W-1:0] sync_q;
   logic [SYNC_W-1:0]                  sync_in;
   logic [SYNC_W-1:0]                  sync_s;
   logic                               act_q;

   assign sync_in = {resp_act_i, crc_disable_i, resp_type_i};
   assign sync_s  = sync_q[SYNC_STAGES-1];

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         sync_q <= '0;
         act_q  <= 1'b0;
      end else begin
         sync_q[0] <= sync_in;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
         // previous synchronized level for the edge detector
         act_q <= sync_s[SYNC_W-1];
      end
   end

   assign resp_start_o  = sync_s[SYNC_W-1] & ~act_q;
   assign crc_disable_o = sync_s[SYNC_W-2];
   assign resp_type_o   = resp_type_t'(sync_s[TYPE_W-1:0]);

   // host settles type and crc setting before it raises the request
   a_settings_stable : assert property (
      @(posedge sd_clk) disable iff (!reset_n)
      resp_start_o |-> ($stable(resp_type_o) && $stable(crc_disable_o))
   );

endmodule

/* rtl/sd_phy_top.sv */
`timescale 1ns/1ns

module sd_phy_top #(
   parameter int RESET_WAIT_CLKS = 60,
   parameter int SYNC_STAGES     = 3
) (
   input  logic               sd_clk,
   input  logic               reset_n,
   input  logic               sd_cmd_i,
   input  sd_pkg::resp_word_t resp_word_i,
   input  sd_pkg::resp_type_t resp_type_i,
   input  logic               resp_act_i,
   input  logic               crc_disable_i,
   output logic               sd_cmd_o,
   output logic               sd_cmd_oe_o,
   output sd_pkg::cmd_word_t  cmd_word_o,
   output logic               cmd_crc_good_o,
   output logic               cmd_act_o,
   output logic               resp_done_o
);
   import sd_pkg::*;

   logic       resp_start;
   resp_type_t resp_type_s;
   logic       crc_disable_s;
   logic       cmd_oe;

   assign sd_cmd_oe_o = cmd_oe;

   sd_host_sync #(
      .SYNC_STAGES   (SYNC_STAGES)
   ) u_host_sync (
      .sd_clk        (sd_clk),
      .reset_n       (reset_n),
      .resp_act_i    (resp_act_i),
      .resp_type_i   (resp_type_i),
      .crc_disable_i (crc_disable_i),
      .resp_start_o  (resp_start),
      .resp_type_o   (resp_type_s),
      .crc_disable_o (crc_disable_s)
   );

   // receiver watches the line only while the transmitter is quiet
   sd_cmd_rx #(
      .RESET_WAIT_CLKS (RESET_WAIT_CLKS)
   ) u_cmd_rx (
      .sd_clk         (sd_clk),
      .reset_n        (reset_n),
      .cmd_i          (sd_cmd_i),
      .cmd_oe_i       (cmd_oe),
      .crc_disable_i  (crc_disable_s),
      .cmd_word_o     (cmd_word_o),
      .cmd_crc_good_o (cmd_crc_good_o),
      .cmd_act_o      (cmd_act_o)
   );

   sd_resp_tx u_resp_tx (
      .sd_clk       (sd_clk),
      .reset_n      (reset_n),
      .resp_start_i (resp_start),
      .resp_type_i  (resp_type_s),
      .resp_word_i  (resp_word_i),
      .cmd_o        (sd_cmd_o),
      .cmd_oe_o     (cmd_oe),
      .resp_done_o  (resp_done_o)
   );

endmodule

/* rtl/sd_pkg.sv */
package sd_pkg;

   // frame lengths on the CMD line
   localparam int CMD_BITS       = 48;
   localparam int LONG_RESP_BITS = 136;
   localparam int CRC7_BITS      = 7;

   // first-sent bit sits at the top of each word
   typedef logic [CMD_BITS-1:0]       cmd_word_t;
   typedef logic [LONG_RESP_BITS-1:0] resp_word_t;
   typedef logic [CRC7_BITS-1:0]      crc7_t;

   // response formats in native SD mode
   typedef enum logic [3:0] {
      RESP_R1  = 4'd1,
      RESP_R1B = 4'd2,
      RESP_R2  = 4'd3,
      RESP_R3  = 4'd4,
      RESP_R6  = 4'd5,
      RESP_R7  = 4'd6
   } resp_type_t;

   // one serial step of x^7 + x^3 + 1, message fed MSB first
   function automatic crc7_t crc7_step(input crc7_t crc, input logic din);
      logic  fb;
      crc7_t nxt;
      fb     = crc[6] ^ din;
      nxt    = {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
      return nxt;
   endfunction

endpackage

/* rtl/sd_resp_tx.sv */
`timescale 1ns/1ns

module sd_resp_tx (
   input  logic               sd_clk,
   input  logic               reset_n,
   input  logic               resp_start_i,
   input  sd_pkg::resp_type_t resp_type_i,
   input  sd_pkg::resp_word_t resp_word_i,
   output logic               cmd_o,
   output logic               cmd_oe_o,
   output logic               resp_done_o
);
   import sd_pkg::*;

   // R2 CRC covers bits 8 to 127 only
   localparam logic [7:0] R2_CRC_FIRST = 8'd8;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PREAMBLE,
      ST_WRITE,
      ST_END
   } tx_state_t;

   tx_state_t   state;
   logic [7:0]  bit_cnt;
   logic [7:0]  crc_start;
   logic [7:0]  last_bit;
   logic        is_long;
   logic        is_r3;
   logic        tx_bit;
   resp_word_t  resp_shift;
   crc7_t       crc;

   assign crc_start = is_long ? 8'(LONG_RESP_BITS - CRC7_BITS - 1)
                              : 8'(CMD_BITS - CRC7_BITS - 1);
   assign last_bit  = is_long ? 8'(LONG_RESP_BITS - 1) : 8'(CMD_BITS - 1);

   // word bits first, then the CRC field, R3 sends ones instead
   always_comb begin
      if (bit_cnt >= crc_start) begin
         tx_bit = is_r3 | crc[CRC7_BITS-1];
      end else begin
         tx_bit = resp_shift[LONG_RESP_BITS-1];
      end
   end

   always_ff @(negedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state       <= ST_IDLE;
         bit_cnt     <= '0;
         cmd_o       <= 1'b1;
         cmd_oe_o    <= 1'b0;
         resp_done_o <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (resp_start_i) begin
                  resp_done_o <= 1'b0;
                  state       <= ST_PREAMBLE;
               end
            end
            ST_PREAMBLE: begin
               // one idle bit between command end and response start
               bit_cnt <= '0;
               state   <= ST_WRITE;
            end
            ST_WRITE: begin
               cmd_oe_o <= 1'b1;
               cmd_o    <= tx_bit;
               bit_cnt  <= bit_cnt + 1'b1;
               if (bit_cnt == last_bit) begin
                  state <= ST_END;
               end
            end
            ST_END: begin
               cmd_oe_o    <= 1'b0;
               resp_done_o <= 1'b1;
               state       <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // response latch, serializer and CRC generator
   always_ff @(negedge sd_clk) begin
      if (state == ST_IDLE && resp_start_i) begin
         resp_shift <= resp_word_i;
         crc        <= '0;
         is_long    <= (resp_type_i == RESP_R2);
         is_r3      <= (resp_type_i == RESP_R3);
      end else if (state == ST_WRITE) begin
         resp_shift <= {resp_shift[LONG_RESP_BITS-2:0], 1'b1};
         if (bit_cnt >= crc_start) begin
            // shifting in ones makes the end bit follow the CRC
            crc <= {crc[CRC7_BITS-2:0], 1'b1};
         end else if (is_long && bit_cnt < R2_CRC_FIRST) begin
            crc <= '0;
         end else begin
            crc <= crc7_step(crc, resp_shift[LONG_RESP_BITS-1]);
         end
      end
   end

   a_oe_low_idle : assert property (
      @(negedge sd_clk) disable iff (!reset_n)
      (state == ST_IDLE) |-> !cmd_oe_o
   );

   a_type_valid : assert property (
      @(negedge sd_clk) disable iff (!reset_n)
      resp_start_i |-> (resp_type_i inside {RESP_R1, RESP_R1B, RESP_R2,
                                             RESP_R3, RESP_R6, RESP_R7})
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the SD PHY testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -f vlog.f \
   --top-module tb_sd_phy -o tb_sd_phy
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_sd_phy)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qxF '** PASS **'; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* sim/tb_sd_tasks.svh */
// Galois LFSR, stepped once for each random bit taken
task automatic take_random(input int nbits, output logic [127:0] value);
   logic lsb;
   value = '0;
   for (int i = 0; i < nbits; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) begin
         lfsr = lfsr ^ 32'h8020_0003;
      end
      value = {value[126:0], lsb};
   end
endtask

// reference CRC7 over the low nbits of msg, MSB first, poly x^7 + x^3 + 1
function automatic crc7_t crc7_model(input logic [135:0] msg, input int nbits);
   crc7_t crc;
   logic  inv;
   crc = '0;
   for (int i = nbits - 1; i >= 0; i--) begin
      inv = msg[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (inv) begin
         crc = crc ^ 7'h09;
      end
   end
   return crc;
endfunction

// host command: start 0, transmission 1, index, argument, CRC7, end 1
function automatic cmd_word_t make_cmd(input logic [5:0] index, input logic [31:0] arg);
   logic [39:0] head;
   head = {2'b01, index, arg};
   return {head, crc7_model(136'(head), 40), 1'b1};
endfunction

task automatic check_cmd(input string what, input cmd_word_t got, input cmd_word_t exp);
   if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
   end
endtask

task automatic check_resp(input string what, input resp_word_t got, input resp_word_t exp);
   if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
   end
endtask

task automatic check_crc(input string what, input crc7_t got, input crc7_t exp);
   if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
   end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
   if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
   end
endtask

task automatic idle_cycles(input int n);
   repeat (n) begin
      @(posedge sd_clk);
      #DRV_DLY;
   end
endtask

// poll the output enable or the done flag once per cycle until it is high
task automatic wait_for(input string what, input bit on_done, output bit ok);
   int cycles;
   ok     = 1'b0;
   cycles = 0;
   while (!ok && cycles < WAIT_TIMEOUT) begin
      @(posedge sd_clk);
      #DRV_DLY;
      ok = on_done ? resp_done_o : sd_cmd_oe_o;
      cycles++;
   end
   if (!ok) begin
      other_count++;
      $display("timeout at %0t ns: %s never went high", $time, what);
   end
endtask

// serial command, one bit per rising edge
task automatic drive_cmd(input cmd_word_t frame);
   for (int k = CMD_BITS - 1; k >= 0; k--) begin
      @(posedge sd_clk);
      #DRV_DLY;
      sd_cmd_i = frame[k];
   end
   // end bit is taken on this edge, results follow it
   @(posedge sd_clk);
   #DRV_DLY;
   sd_cmd_i = 1'b1;
endtask

// response bits land top-aligned in frame
task automatic receive_frame(input int nbits, output resp_word_t frame, output bit ok);
   frame = '0;
   wait_for("CMD output enable", 1'b0, ok);
   if (ok) begin
      for (int k = 0; k < nbits; k++) begin
         if (k > 0) begin
            @(posedge sd_clk);
            #DRV_DLY;
         end
         frame[LONG_RESP_BITS-1-k] = sd_cmd_o;
      end
      wait_for("response done", 1'b1, ok);
   end
endtask

task automatic request_resp(input resp_type_t rtype, input resp_word_t word, input int nbits,
                            output resp_word_t frame);
   bit ok;
   resp_word_i = word;
   resp_type_i = rtype;
   idle_cycles(1);
   resp_act_i = 1'b1;
   receive_frame(nbits, frame, ok);
   if (ok) begin
      check_bit("CMD output enable after response", sd_cmd_oe_o, 1'b0);
   end
   resp_act_i = 1'b0;
   // let the low level pass the synchronizer before the next request
   idle_cycles(SYNC_STAGES + 2);
endtask

/* sim/tb_sd_phy.sv */
`timescale 1ns/1ns

module tb_sd_phy;
   import sd_pkg::*;

   localparam int RESET_WAIT_CLKS = 60;
   localparam int SYNC_STAGES     = 3;
   localparam int DRV_DLY         = 5;
   localparam int WAIT_TIMEOUT    = 20;

   logic       sd_clk;
   logic       reset_n;
   logic       sd_cmd_i;
   resp_word_t resp_word_i;
   resp_type_t resp_type_i;
   logic       resp_act_i;
   logic       crc_disable_i;
   logic       sd_cmd_o;
   logic       sd_cmd_oe_o;
   cmd_word_t  cmd_word_o;
   logic       cmd_crc_good_o;
   logic       cmd_act_o;
   logic       resp_done_o;

   int          mismatch_count;
   int          other_count;
   logic [31:0] lfsr;

   sd_phy_top #(
      .RESET_WAIT_CLKS (RESET_WAIT_CLKS),
      .SYNC_STAGES     (SYNC_STAGES)
   ) u_dut (
      .sd_clk         (sd_clk),
      .reset_n        (reset_n),
      .sd_cmd_i       (sd_cmd_i),
      .resp_word_i    (resp_word_i),
      .resp_type_i    (resp_type_i),
      .resp_act_i     (resp_act_i),
      .crc_disable_i  (crc_disable_i),
      .sd_cmd_o       (sd_cmd_o),
      .sd_cmd_oe_o    (sd_cmd_oe_o),
      .cmd_word_o     (cmd_word_o),
      .cmd_crc_good_o (cmd_crc_good_o),
      .cmd_act_o      (cmd_act_o),
      .resp_done_o    (resp_done_o)
   );

   initial begin
      sd_clk = 1'b0;
      forever #50 sd_clk = ~sd_clk;
   end

`include "tb_sd_tasks.svh"

   task automatic test_reset_state();
      check_bit("CMD output enable after reset", sd_cmd_oe_o, 1'b0);
      check_bit("response done after reset", resp_done_o, 1'b0);
      check_bit("CRC good after reset", cmd_crc_good_o, 1'b0);
      check_bit("command active after reset", cmd_act_o, 1'b0);
   endtask

   task automatic test_good_cmd();
      logic [127:0] rnd;
      cmd_word_t    frame;
      take_random(32, rnd);
      frame = make_cmd(6'd17, rnd[31:0]);
      drive_cmd(frame);
      check_cmd("command word", cmd_word_o, frame);
      check_bit("CRC good on valid command", cmd_crc_good_o, 1'b1);
      check_bit("transmission bit", cmd_act_o, frame[46]);
      idle_cycles(2);
   endtask

   task automatic test_bad_crc();
      logic [127:0] rnd;
      cmd_word_t    frame;
      take_random(32, rnd);
      // flip one bit inside the CRC field
      frame = make_cmd(6'd8, rnd[31:0]) ^ 48'h10;
      drive_cmd(frame);
      check_cmd("command word with bad CRC", cmd_word_o, frame);
      check_bit("CRC good on corrupted command", cmd_crc_good_o, 1'b0);
      crc_disable_i = 1'b1;
      idle_cycles(SYNC_STAGES + 2);
      drive_cmd(frame);
      check_bit("CRC good with check disabled", cmd_crc_good_o, 1'b1);
      crc_disable_i = 1'b0;
      idle_cycles(SYNC_STAGES + 2);
   endtask

   // R1 and R3 share the short frame, R3 carries ones in its CRC field
   task automatic test_short_resp(input resp_type_t rtype);
      logic [127:0] rnd;
      resp_word_t   word;
      resp_word_t   frame;
      crc7_t        exp_crc;
      take_random(128, rnd);
      word = {2'b00, rnd[37:0], rnd[95:0]};
      request_resp(rtype, word, CMD_BITS, frame);
      check_resp("short response bits 0 to 39", {frame[135:96], 96'b0}, {word[135:96], 96'b0});
      exp_crc = (rtype == RESP_R3) ? 7'h7f : crc7_model(136'(word[135:96]), 40);
      check_crc("short response CRC", frame[95:89], exp_crc);
      check_bit("short response end bit", frame[88], 1'b1);
      check_bit("response done after short frame", resp_done_o, 1'b1);
   endtask

   task automatic test_r2();
      logic [127:0] rnd;
      resp_word_t   word;
      resp_word_t   frame;
      take_random(128, rnd);
      word = {2'b00, 6'b111111, rnd};
      request_resp(RESP_R2, word, LONG_RESP_BITS, frame);
      check_resp("R2 bits 0 to 127", {frame[135:8], 8'b0}, {word[135:8], 8'b0});
      check_crc("R2 CRC", frame[7:1], crc7_model(136'(word[127:8]), 120));
      check_bit("R2 end bit", frame[0], 1'b1);
      check_bit("response done after R2", resp_done_o, 1'b1);
   endtask

   initial begin
      sd_cmd_i       = 1'b1;
      resp_word_i    = '0;
      resp_type_i    = RESP_R1;
      resp_act_i     = 1'b0;
      crc_disable_i  = 1'b0;
      reset_n        = 1'b0;
      lfsr           = 32'h606;
      mismatch_count = 0;
      other_count    = 0;
      repeat (3) @(posedge sd_clk);
      #DRV_DLY;
      reset_n = 1'b1;
      test_reset_state();
      // host idle clocks with CMD high before the first command
      idle_cycles(80);
      test_good_cmd();
      test_bad_crc();
      test_short_resp(RESP_R1);
      test_r2();
      test_short_resp(RESP_R3);
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* vlog.f */
+incdir+sim
rtl/sd_pkg.sv
rtl/sd_host_sync.sv
rtl/sd_cmd_rx.sv
rtl/sd_resp_tx.sv
rtl/sd_phy_top.sv
sim/tb_sd_phy.sv
